/* list.f */
+incdir+.
rv32_pkg.sv
rv32_stage_reg.sv
rv32_decoder.sv
rv32_regfile.sv
rv32_execute.sv
rv32_core.sv
rv32_core_sva.sv
rv32_core_checker.sv
tb_rv32_core.sv

/* rv32_core.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module rv32_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] instr_addr,
  input  logic [`RV_XLEN-1:0] instr_rdata,
  output logic                data_we,
  output logic [`RV_XLEN-1:0] data_addr,
  output logic [`RV_XLEN-1:0] data_wdata
);
  import rv32_pkg::*;

  localparam fd_payload_t fd_bubble = '{pc: `RV_RESET_PC, instr: `RV_NOP};
  localparam de_payload_t de_bubble = '0;

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_next;
  fd_payload_t         fd_d;
  fd_payload_t         fd_q;
  de_payload_t         de_d;
  de_payload_t         de_q;
  ctrl_t               dec_ctrl;
  logic [4:0]          dec_rs1;
  logic [4:0]          dec_rs2;
  logic [4:0]          dec_rd;
  logic [`RV_XLEN-1:0] dec_imm;
  logic [`RV_XLEN-1:0] rf_rdata1;
  logic [`RV_XLEN-1:0] rf_rdata2;
  logic [`RV_XLEN-1:0] rs1_val;
  logic [`RV_XLEN-1:0] rs2_val;
  logic                ex_we;
  logic [4:0]          ex_waddr;
  logic [`RV_XLEN-1:0] ex_wdata;
  logic                redirect;
  logic [`RV_XLEN-1:0] redirect_pc;

  // Fetch
  assign pc_next    = redirect ? redirect_pc : pc + 4;
  assign instr_addr = pc;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign fd_d = '{pc: pc, instr: instr_rdata};

  rv32_stage_reg #(.payload_t(fd_payload_t), .bubble(fd_bubble)) i_fd_reg (
    .clk   (clk),
    .rst   (rst),
    .flush (redirect),
    .d     (fd_d),
    .q     (fd_q)
  );

  // Decode
  rv32_decoder i_decoder (
    .instr (fd_q.instr),
    .ctrl  (dec_ctrl),
    .rs1   (dec_rs1),
    .rs2   (dec_rs2),
    .rd    (dec_rd),
    .imm   (dec_imm)
  );

  rv32_regfile i_regfile (
    .clk    (clk),
    .rst    (rst),
    .we     (ex_we),
    .waddr  (ex_waddr),
    .wdata  (ex_wdata),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  // The execute result is not in the regfile until the next edge
  assign rs1_val = (ex_we && (ex_waddr != 5'd0) && (ex_waddr == dec_rs1)) ? ex_wdata
                                                                          : rf_rdata1;
  assign rs2_val = (ex_we && (ex_waddr != 5'd0) && (ex_waddr == dec_rs2)) ? ex_wdata
                                                                          : rf_rdata2;

  assign de_d = '{pc: fd_q.pc, ctrl: dec_ctrl, rd: dec_rd,
                  rs1_val: rs1_val, rs2_val: rs2_val, imm: dec_imm};

  rv32_stage_reg #(.payload_t(de_payload_t), .bubble(de_bubble)) i_de_reg (
    .clk   (clk),
    .rst   (rst),
    .flush (redirect),
    .d     (de_d),
    .q     (de_q)
  );

  // Execute and write back
  rv32_execute i_execute (
    .stage       (de_q),
    .we          (ex_we),
    .waddr       (ex_waddr),
    .wdata       (ex_wdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .data_we     (data_we),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata)
  );

endmodule

/* rv32_core_checker.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module rv32_core_checker (
  input logic                clk,
  input logic                rst,
  input logic [`RV_XLEN-1:0] instr_addr,
  input logic                data_we,
  input logic [`RV_XLEN-1:0] data_addr,
  input logic [`RV_XLEN-1:0] data_wdata
);

  logic [`RV_XLEN-1:0] exp_pc [$];
  logic [`RV_XLEN-1:0] exp_addr [$];
  logic [`RV_XLEN-1:0] exp_data [$];
  logic [`RV_XLEN-1:0] fetch_q [$];
  logic [`RV_XLEN-1:0] want_pc;
  logic [`RV_XLEN-1:0] want_addr;
  logic [`RV_XLEN-1:0] want_data;
  int                  value_errors = 0;
  int                  extra_stores = 0;
  int                  missing_stores = 0;
  int                  store_count = 0;
  bit                  started = 1'b0;

  task automatic add_expected(input logic [`RV_XLEN-1:0] pc, input logic [`RV_XLEN-1:0] addr,
                              input logic [`RV_XLEN-1:0] data);
    exp_pc.push_back(pc);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic report_missing();
    missing_stores = exp_addr.size();
    if (missing_stores != 0) begin
      $display("%0d expected stores never appeared on the store port", missing_stores);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      fetch_q.delete();
    end else begin
      if (!started) begin
        started = 1'b1;
        if (instr_addr !== `RV_RESET_PC) begin
          value_errors++;
          $display("error at %0t: first fetch address %h, expected %h", $time, instr_addr,
                   `RV_RESET_PC);
        end
      end
      if (data_we === 1'b1) begin
        store_count++;
        if (exp_addr.size() == 0) begin
          extra_stores++;
          $display("Unexpected store to %h at time %0t after all expected stores were seen",
                   data_addr, $time);
        end else begin
          want_pc   = exp_pc.pop_front();
          want_addr = exp_addr.pop_front();
          want_data = exp_data.pop_front();
          if (data_addr !== want_addr || data_wdata !== want_data) begin
            value_errors++;
            $display("error at %0t: store %h <= %h, expected %h <= %h", $time, data_addr,
                     data_wdata, want_addr, want_data);
          end
          // Fetched two cycles before it reaches execute
          if (fetch_q.size() < 2 || fetch_q[0] !== want_pc) begin
            value_errors++;
            $display("error at %0t: store from pc %h not fetched two cycles earlier",
                     $time, want_pc);
          end
        end
      end
      fetch_q.push_back(instr_addr);
      if (fetch_q.size() > 2) void'(fetch_q.pop_front());
    end
  end

endmodule

/* rv32_core_sva.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module rv32_core_sva (
  input logic                clk,
  input logic                rst,
  input logic [`RV_XLEN-1:0] instr_addr,
  input logic                data_we,
  input logic [`RV_XLEN-1:0] data_addr
);

  int fail_count = 0;

  a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(instr_addr) && (instr_addr[1:0] == 2'b00))
  else begin
    $error("instr_addr unknown or not word aligned");
    fail_count++;
  end

  a_no_store_in_reset: assert property (@(posedge clk) rst |-> !data_we)
  else begin
    $error("data_we high during reset");
    fail_count++;
  end

  a_store_aligned: assert property (@(posedge clk) disable iff (rst)
    data_we |-> (data_addr[1:0] == 2'b00))
  else begin
    $error("store address not word aligned");
    fail_count++;
  end

endmodule

/* rv32_decoder.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module rv32_decoder (
  input  logic [`RV_XLEN-1:0] instr,
  output rv32_pkg::ctrl_t     ctrl,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [4:0]          rd,
  output logic [`RV_XLEN-1:0] imm
);
  import rv32_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       alt;

  // Shared by register and immediate forms, SUB only exists in the register form
  function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic f7_alt,
                                           input logic is_reg);
    alu_op_t op;
    case (f3)
      3'b000:  op = (f7_alt && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign alt    = instr[30];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  always_comb begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      OPC_OP: begin
        ctrl.alu_op    = funct_to_alu(funct3, alt, 1'b1);
        ctrl.reg_write = 1'b1;
      end
      OPC_OP_IMM: begin
        ctrl.alu_op    = funct_to_alu(funct3, alt, 1'b0);
        ctrl.op2_sel   = OP2_IMM;
        ctrl.reg_write = 1'b1;
        imm            = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
      end
      OPC_LUI: begin
        ctrl.op1_sel   = OP1_ZERO;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.wb_sel    = WB_IMM;
        ctrl.reg_write = 1'b1;
        imm            = {instr[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        ctrl.op1_sel   = OP1_PC;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.reg_write = 1'b1;
        imm            = {instr[31:12], 12'b0};
      end
      OPC_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.wb_sel    = WB_PC4;
        ctrl.reg_write = 1'b1;
        imm = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      OPC_JALR: begin
        // Target comes out of the ALU as rs1 + imm
        ctrl.jump      = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.op2_sel   = OP2_IMM;
        ctrl.wb_sel    = WB_PC4;
        ctrl.reg_write = 1'b1;
        imm            = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
      end
      OPC_BRANCH: begin
        // funct3 010 and 011 are reserved
        if (funct3[2:1] != 2'b01) begin
          ctrl.branch  = 1'b1;
          ctrl.br_cond = branch_t'(funct3);
          imm = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        end
      end
      OPC_STORE: begin
        // Word stores only
        if (funct3 == 3'b010) begin
          ctrl.store   = 1'b1;
          ctrl.op2_sel = OP2_IMM;
          imm          = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
        end
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* rv32_execute.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module rv32_execute (
  input  rv32_pkg::de_payload_t stage,
  output logic                  we,
  output logic [4:0]            waddr,
  output logic [`RV_XLEN-1:0]   wdata,
  output logic                  redirect,
  output logic [`RV_XLEN-1:0]   redirect_pc,
  output logic                  data_we,
  output logic [`RV_XLEN-1:0]   data_addr,
  output logic [`RV_XLEN-1:0]   data_wdata
);
  import rv32_pkg::*;

  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] alu_res;
  logic [4:0]          shamt;
  logic                br_taken;

  always_comb begin
    case (stage.ctrl.op1_sel)
      OP1_PC:   op1 = stage.pc;
      OP1_ZERO: op1 = '0;
      default:  op1 = stage.rs1_val;
    endcase
  end

  assign op2   = (stage.ctrl.op2_sel == OP2_IMM) ? stage.imm : stage.rs2_val;
  assign shamt = op2[4:0];

  always_comb begin
    case (stage.ctrl.alu_op)
      ALU_SUB:  alu_res = op1 - op2;
      ALU_SLL:  alu_res = op1 << shamt;
      ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, op1 < op2};
      ALU_XOR:  alu_res = op1 ^ op2;
      ALU_SRL:  alu_res = op1 >> shamt;
      ALU_SRA:  alu_res = $signed(op1) >>> shamt;
      ALU_OR:   alu_res = op1 | op2;
      ALU_AND:  alu_res = op1 & op2;
      default:  alu_res = op1 + op2;
    endcase
  end

  // Branch compare always works on the two register operands
  always_comb begin
    case (stage.ctrl.br_cond)
      BR_EQ:   br_taken = (stage.rs1_val == stage.rs2_val);
      BR_NE:   br_taken = (stage.rs1_val != stage.rs2_val);
      BR_LT:   br_taken = ($signed(stage.rs1_val) < $signed(stage.rs2_val));
      BR_GE:   br_taken = ($signed(stage.rs1_val) >= $signed(stage.rs2_val));
      BR_LTU:  br_taken = (stage.rs1_val < stage.rs2_val);
      BR_GEU:  br_taken = (stage.rs1_val >= stage.rs2_val);
      default: br_taken = 1'b0;
    endcase
  end

  assign redirect = stage.ctrl.jump || (stage.ctrl.branch && br_taken);

  // JALR target is rs1 + imm from the ALU with bit zero cleared
  assign redirect_pc = stage.ctrl.is_jalr ? {alu_res[`RV_XLEN-1:1], 1'b0}
                                          : stage.pc + stage.imm;

  always_comb begin
    case (stage.ctrl.wb_sel)
      WB_PC4:  wdata = stage.pc + 4;
      WB_IMM:  wdata = stage.imm;
      default: wdata = alu_res;
    endcase
  end

  assign we    = stage.ctrl.reg_write;
  assign waddr = stage.rd;

  // Store address is rs1 + imm, one strobe per store
  assign data_we    = stage.ctrl.store;
  assign data_addr  = alu_res;
  assign data_wdata = stage.rs2_val;

endmodule

/* rv32_pkg.sv */
`include "rv32_settings.svh"

package rv32_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_STORE  = 7'b0100011
  } opcode_t;

  // ALU_ADD sits at zero so an all-zero control word is harmless
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_t;

  typedef enum logic [1:0] {
    OP1_RS1  = 2'd0,
    OP1_PC   = 2'd1,
    OP1_ZERO = 2'd2
  } op1_sel_t;

  typedef enum logic {
    OP2_RS2 = 1'b0,
    OP2_IMM = 1'b1
  } op2_sel_t;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_PC4 = 2'd1,
    WB_IMM = 2'd2
  } wb_sel_t;

  // Encoded exactly as the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_t;

  typedef struct packed {
    alu_op_t  alu_op;
    op1_sel_t op1_sel;
    op2_sel_t op2_sel;
    wb_sel_t  wb_sel;
    branch_t  br_cond;
    logic     reg_write;
    logic     branch;
    logic     jump;
    logic     is_jalr;
    logic     store;
  } ctrl_t;

  // Fetch to decode
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
  } fd_payload_t;

  // Decode to execute, operands already forwarded
  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    ctrl_t               ctrl;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] imm;
  } de_payload_t;

endpackage

/* rv32_regfile.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module rv32_regfile (
  input  logic                clk,
  input  logic                rst,
  input  logic                we,
  input  logic [4:0]          waddr,
  input  logic [`RV_XLEN-1:0] wdata,
  input  logic [4:0]          raddr1,
  input  logic [4:0]          raddr2,
  output logic [`RV_XLEN-1:0] rdata1,
  output logic [`RV_XLEN-1:0] rdata2
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  // x0 is cleared by reset and never written afterwards
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

/* rv32_settings.svh */
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural integer registers
`define RV_NREGS 32

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// Bubble instruction, addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

/* rv32_stage_reg.sv */
`timescale 1ns/1ps

module rv32_stage_reg #(
  parameter type      payload_t = logic,
  parameter payload_t bubble    = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // Reset and flush both drop a bubble into the stage
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      q <= bubble;
    end else if (flush) begin
      q <= bubble;
    end else begin
      q <= d;
    end
  end

endmodule

/* tb_rv32_core.sv */
`timescale 1ns/1ps
`include "rv32_settings.svh"

module tb_rv32_core;

  localparam int PROG_LEN  = 200;
  localparam int RESET_CYC = 10;
  localparam int TAIL_CYC  = 10;

  // Instruction kinds used by the generator and the model
  localparam int K_ALU_R = 0;
  localparam int K_ALU_I = 1;
  localparam int K_LUI   = 2;
  localparam int K_AUIPC = 3;
  localparam int K_SW    = 4;
  localparam int K_BR    = 5;
  localparam int K_JAL   = 6;
  localparam int K_JALR  = 7;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] instr_addr;
  logic [`RV_XLEN-1:0] instr_rdata;
  logic                data_we;
  logic [`RV_XLEN-1:0] data_addr;
  logic [`RV_XLEN-1:0] data_wdata;

  integer              seed;
  int                  total;
  logic [`RV_XLEN-1:0] prog [PROG_LEN];
  int                  kind [PROG_LEN];
  logic [2:0]          f3 [PROG_LEN];
  logic                alt [PROG_LEN];
  logic [4:0]          rd [PROG_LEN];
  logic [4:0]          rs1 [PROG_LEN];
  logic [4:0]          rs2 [PROG_LEN];
  logic [`RV_XLEN-1:0] imm [PROG_LEN];
  bit                  is_target [PROG_LEN];

  rv32_core i_rv32_core (
    .clk         (clk),
    .rst         (rst),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .data_we     (data_we),
    .data_addr   (data_addr),
    .data_wdata  (data_wdata)
  );

  rv32_core_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .instr_addr (instr_addr),
    .data_we    (data_we),
    .data_addr  (data_addr),
    .data_wdata (data_wdata)
  );

  bind rv32_core rv32_core_sva i_sva (
    .clk        (clk),
    .rst        (rst),
    .instr_addr (instr_addr),
    .data_we    (data_we),
    .data_addr  (data_addr)
  );

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Small register window so that dependencies are frequent
  function automatic logic [4:0] pick_reg();
    return 5'(rand_below(8));
  endfunction

  // Integer operations as the RV32I spec defines them
  function automatic logic [`RV_XLEN-1:0] alu_ref(input logic [2:0] op, input logic sub_sra,
                                                  input logic is_reg,
                                                  input logic [`RV_XLEN-1:0] a,
                                                  input logic [`RV_XLEN-1:0] b);
    logic [`RV_XLEN-1:0] r;
    case (op)
      3'd0: r = (sub_sra && is_reg) ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 1 : 0;
      3'd3: r = (a < b) ? 1 : 0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (sub_sra) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic bit branch_ref(input logic [2:0] op, input logic [`RV_XLEN-1:0] a,
                                    input logic [`RV_XLEN-1:0] b);
    case (op)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [`RV_XLEN-1:0] encode(input int i);
    logic [`RV_XLEN-1:0] v;
    v = imm[i];
    case (kind[i])
      K_ALU_R: return {1'b0, alt[i], 5'b0, rs2[i], rs1[i], f3[i], rd[i], 7'b0110011};
      K_ALU_I: return {v[11:0], rs1[i], f3[i], rd[i], 7'b0010011};
      K_LUI:   return {v[31:12], rd[i], 7'b0110111};
      K_AUIPC: return {v[31:12], rd[i], 7'b0010111};
      K_SW:    return {v[11:5], rs2[i], rs1[i], 3'b010, v[4:0], 7'b0100011};
      K_BR:    return {v[12], v[10:5], rs2[i], rs1[i], f3[i], v[4:1], v[11], 7'b1100011};
      K_JAL:   return {v[20], v[10:1], v[11], v[19:12], rd[i], 7'b1101111};
      default: return {v[11:0], rs1[i], 3'b000, rd[i], 7'b1100111};
    endcase
  endfunction

  // Anything outside the program reads as a bubble
  function automatic logic [`RV_XLEN-1:0] fetch_word(input logic [`RV_XLEN-1:0] addr);
    if (addr[1:0] == 2'b00 && (addr >> 2) < PROG_LEN) return prog[addr >> 2];
    return `RV_NOP;
  endfunction

  task automatic generate_program();
    int i;
    int sel;
    int tgt;
    int br_sel;
    logic [`RV_XLEN-1:0] rv;
    i = 0;
    while (i < PROG_LEN - 1) begin
      sel       = rand_below(17);
      rv        = $random(seed);
      kind[i]   = K_ALU_R;
      f3[i]     = 3'(rand_below(8));
      alt[i]    = 1'b0;
      rd[i]     = pick_reg();
      rs1[i]    = pick_reg();
      rs2[i]    = pick_reg();
      imm[i]    = '0;
      if (sel == 16 && i + 3 <= PROG_LEN - 1 && !is_target[i + 1]) begin
        // AUIPC x, 0 then JALR forward off the AUIPC address
        tgt = i + 2 + rand_below(4);
        if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
        kind[i]       = K_AUIPC;
        rd[i]         = 5'(1 + rand_below(7));
        kind[i + 1]   = K_JALR;
        f3[i + 1]     = 3'b000;
        alt[i + 1]    = 1'b0;
        rs1[i + 1]    = rd[i];
        rs2[i + 1]    = 5'd0;
        rd[i + 1]     = pick_reg();
        imm[i + 1]    = (tgt - i) * 4;
        is_target[tgt] = 1'b1;
        i += 2;
      end else begin
        if (sel < 5) begin
          if (f3[i] == 3'd0 || f3[i] == 3'd5) alt[i] = rv[30];
        end else if (sel < 9) begin
          kind[i] = K_ALU_I;
          if (f3[i] == 3'd1) begin
            imm[i] = {27'b0, rv[4:0]};
          end else if (f3[i] == 3'd5) begin
            alt[i] = rv[30];
            imm[i] = {21'b0, rv[30], 5'b0, rv[4:0]};
          end else begin
            imm[i] = {{20{rv[11]}}, rv[11:0]};
          end
        end else if (sel < 11) begin
          kind[i] = (sel == 9) ? K_LUI : K_AUIPC;
          imm[i]  = {rv[31:12], 12'b0};
        end else if (sel < 13) begin
          kind[i] = K_SW;
          rs1[i]  = 5'd0;
          imm[i]  = {21'b0, rv[10:2], 2'b0};
        end else if (sel < 15) begin
          kind[i] = K_BR;
          br_sel  = rand_below(6);
          f3[i]   = 3'((br_sel < 2) ? br_sel : br_sel + 2);
          tgt     = i + 2 + rand_below(3);
          if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
          imm[i]  = (tgt - i) * 4;
          is_target[tgt] = 1'b1;
        end else begin
          kind[i] = K_JAL;
          tgt     = i + 1 + rand_below(4);
          if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
          imm[i]  = (tgt - i) * 4;
          is_target[tgt] = 1'b1;
        end
        i++;
      end
    end
    // Final self-loop
    kind[PROG_LEN - 1] = K_JAL;
    rd[PROG_LEN - 1]   = 5'd0;
    imm[PROG_LEN - 1]  = '0;
    for (int k = 0; k < PROG_LEN; k++) begin
      prog[k] = encode(k);
    end
  endtask

  // Architectural execution, one instruction per step
  task automatic run_model();
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] res;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic                wr;
    int                  idx;
    int                  next;
    int                  steps;
    foreach (regs[r]) regs[r] = '0;
    idx   = 0;
    steps = 0;
    while (idx != PROG_LEN - 1 && steps < 4 * PROG_LEN) begin
      pc   = `RV_RESET_PC + idx * 4;
      a    = regs[rs1[idx]];
      b    = regs[rs2[idx]];
      next = idx + 1;
      wr   = 1'b1;
      res  = '0;
      case (kind[idx])
        K_ALU_R: res = alu_ref(f3[idx], alt[idx], 1'b1, a, b);
        K_ALU_I: res = alu_ref(f3[idx], alt[idx], 1'b0, a, imm[idx]);
        K_LUI:   res = imm[idx];
        K_AUIPC: res = pc + imm[idx];
        K_SW: begin
          wr = 1'b0;
          i_checker.add_expected(pc, a + imm[idx], b);
        end
        K_BR: begin
          wr = 1'b0;
          if (branch_ref(f3[idx], a, b)) next = idx + int'(imm[idx] >> 2);
        end
        K_JAL: begin
          res  = pc + 4;
          next = idx + int'(imm[idx] >> 2);
        end
        default: begin
          res  = pc + 4;
          next = int'((((a + imm[idx]) & ~32'd1) - `RV_RESET_PC) >> 2);
        end
      endcase
      if (wr && rd[idx] != 5'd0) regs[rd[idx]] = res;
      idx = next;
      steps++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    instr_rdata <= fetch_word(instr_addr);
  end

  initial begin
    seed        = 56904;
    rst         = 1'b1;
    instr_rdata = `RV_NOP;
    generate_program();
    run_model();
    repeat (RESET_CYC) @(negedge clk);
    rst = 1'b0;
    // Run until the final loop is fetched, then drain the pipeline
    while (instr_addr !== `RV_RESET_PC + (PROG_LEN - 1) * 4) @(posedge clk);
    repeat (TAIL_CYC) @(posedge clk);
    i_checker.report_missing();
    total = i_checker.value_errors + i_checker.extra_stores + i_checker.missing_stores
            + i_rv32_core.i_sva.fail_count;
    $display("Stores %0d, value errors %0d, extra %0d, missing %0d, assertion failures %0d",
             i_checker.store_count, i_checker.value_errors, i_checker.extra_stores,
             i_checker.missing_stores, i_rv32_core.i_sva.fail_count);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Five cycles per instruction on top of reset
  initial begin
    repeat (5 * PROG_LEN + RESET_CYC) @(posedge clk);
    $display("Timeout: the core did not reach the end of the program in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule
